// ==== audio_defines.svh ====
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Bits kept from each 32-bit slot, at most 32
`define SAMPLE_WIDTH 16

// Ring of 2**RAM_ADDR_WIDTH stereo frames
`define RAM_ADDR_WIDTH 4

// Frames between write and read pointer, less than the ring depth
`define ECHO_DELAY 3

`endif

// ==== audio_pkg.sv ====
`default_nettype none

`include "audio_defines.svh"

package audio_pkg;

    typedef struct packed {
        logic [`SAMPLE_WIDTH-1:0] left;
        logic [`SAMPLE_WIDTH-1:0] right;
    } frame_t;  // One RAM word

    typedef enum logic [1:0] {
        gnt_none,
        gnt_capture,
        gnt_playback,
        gnt_host
    } grant_t;

    typedef enum logic [1:0] {
        st_wait_fill,
        st_idle,
        st_request,
        st_hold
    } reader_state_t;

endpackage

`default_nettype wire

// ==== mem_req_if.sv ====
`default_nettype none

`include "audio_defines.svh"

interface mem_req_if import audio_pkg::*; ();

    logic                       req;     // Level, held until gnt
    logic                       we;
    logic [`RAM_ADDR_WIDTH-1:0] addr;
    frame_t                     wdata;
    logic                       gnt;     // Access happens in this cycle
    frame_t                     rdata;
    logic                       rvalid;  // One cycle after a read gnt

    modport requester (output req, we, addr, wdata, input gnt, rdata, rvalid);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

// ==== i2s_port.sv ====
`default_nettype none

`include "audio_defines.svh"

module i2s_port import audio_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   bclk,
    input  logic   lrclk,
    input  logic   adcda,
    input  frame_t play,
    output frame_t rx,
    output logic   dataready,
    output logic   bclk_s,
    output logic   lrclk_s,
    output logic   dacda
);

    // ########################################
    // Pin synchronizers and edge strobes

    logic [2:0] bclk_sync;
    logic [2:0] lrclk_sync;
    logic [1:0] adcda_sync;
    logic       bclk_rise;
    logic       bclk_fall;
    logic       lrclk_change;
    logic       lrclk_was_high;

    always_ff @(posedge clk) begin
        if (reset) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            adcda_sync <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], bclk};
            lrclk_sync <= {lrclk_sync[1:0], lrclk};
            adcda_sync <= {adcda_sync[0], adcda};
        end
    end

    assign bclk_s         = bclk_sync[1];
    assign lrclk_s        = lrclk_sync[1];
    assign bclk_rise      = bclk_s & ~bclk_sync[2];
    assign bclk_fall      = ~bclk_s & bclk_sync[2];
    assign lrclk_was_high = lrclk_sync[2];
    assign lrclk_change   = lrclk_s ^ lrclk_was_high;

    // ########################################
    // Receive path

    logic [31:0] rx_shift;

    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            rx_shift <= {rx_shift[30:0], adcda_sync[1]};
        end
    end

    // The whole slot is in rx_shift by the time lrclk turns over
    always_ff @(posedge clk) begin
        if (lrclk_change) begin
            if (lrclk_was_high) begin
                rx.right <= rx_shift[31 -: `SAMPLE_WIDTH];
            end else begin
                rx.left <= rx_shift[31 -: `SAMPLE_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dataready <= 1'b0;
        end else begin
            dataready <= lrclk_change & lrclk_was_high;  // Right slot done, frame complete
        end
    end

    // ########################################
    // Transmit path

    logic [4:0]               bit_cnt;
    frame_t                   hold;
    logic [31:0]              tx_shift;
    logic [`SAMPLE_WIDTH-1:0] tx_sample;

    assign tx_sample = lrclk_s ? hold.right : hold.left;

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= '0;
            hold     <= '0;
            tx_shift <= '0;
        end else if (lrclk_change) begin
            bit_cnt  <= '0;
            tx_shift <= 32'(tx_sample) << (32 - `SAMPLE_WIDTH);  // MSB on the line right away
        end else if (bclk_fall) begin
            bit_cnt  <= bit_cnt + 5'd1;
            tx_shift <= {tx_shift[30:0], 1'b0};
            if (lrclk_s && bit_cnt == 5'd30) begin
                hold <= play;  // Last falling edge of the frame
            end
        end
    end

    assign dacda = tx_shift[31];

    a_dataready_single : assert property (
        @(posedge clk) disable iff (reset) dataready |=> !dataready
    );

endmodule

`default_nettype wire

// ==== capture_writer.sv ====
`default_nettype none

`include "audio_defines.svh"

module capture_writer import audio_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  frame_t            rx,
    input  logic              dataready,
    mem_req_if.requester      mem
);

    logic [`RAM_ADDR_WIDTH-1:0] wr_ptr;
    frame_t                     wr_frame;
    logic                       wr_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_req <= 1'b0;
            wr_ptr <= '0;
        end else if (dataready) begin
            wr_req <= 1'b1;
        end else if (mem.gnt) begin
            wr_req <= 1'b0;
            wr_ptr <= wr_ptr + 1'b1;  // Wraps with the ring
        end
    end

    always_ff @(posedge clk) begin
        if (dataready) begin
            wr_frame <= rx;
        end
    end

    assign mem.req   = wr_req;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_ptr;
    assign mem.wdata = wr_frame;

    // A write must retire inside one frame period
    a_no_overrun : assert property (
        @(posedge clk) disable iff (reset) mem.req |-> !dataready
    );

endmodule

`default_nettype wire

// ==== playback_reader.sv ====
`default_nettype none

`include "audio_defines.svh"

module playback_reader import audio_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              dataready,
    output frame_t            play,
    mem_req_if.requester      mem
);

    localparam logic [`RAM_ADDR_WIDTH-1:0] fill_last = `ECHO_DELAY - 1;

    reader_state_t              state;
    logic [`RAM_ADDR_WIDTH-1:0] fill_cnt;
    logic [`RAM_ADDR_WIDTH-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_wait_fill;
            fill_cnt <= '0;
            rd_ptr   <= '0;
            play     <= '0;
        end else begin
            case (state)
                st_wait_fill: begin
                    if (dataready) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == fill_last) begin
                            state <= st_idle;  // Ring now ECHO_DELAY frames ahead
                        end
                    end
                end
                st_idle: begin
                    if (dataready) begin
                        state <= st_request;
                    end
                end
                st_request: begin
                    if (mem.gnt) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= st_hold;
                    end
                end
                st_hold: begin
                    if (mem.rvalid) begin
                        play  <= mem.rdata;  // Kept until the next read returns
                        state <= st_idle;
                    end
                end
                default: state <= st_wait_fill;
            endcase
        end
    end

    assign mem.req   = (state == st_request);
    assign mem.we    = 1'b0;
    assign mem.addr  = rd_ptr;
    assign mem.wdata = '0;

endmodule

`default_nettype wire

// ==== shared_frame_ram.sv ====
`default_nettype none

`include "audio_defines.svh"

module shared_frame_ram import audio_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    mem_req_if.arbiter  cap,
    mem_req_if.arbiter  play,
    mem_req_if.arbiter  host
);

    localparam int depth = 1 << `RAM_ADDR_WIDTH;

    frame_t                     ram [depth];
    grant_t                     grant;
    grant_t                     rd_grant;
    logic                       sel_we;
    logic [`RAM_ADDR_WIDTH-1:0] sel_addr;
    frame_t                     sel_wdata;
    frame_t                     rd_data;

    // Fixed priority, capture wins over playback, playback over host
    always_comb begin
        if (cap.req) begin
            grant = gnt_capture;
        end else if (play.req) begin
            grant = gnt_playback;
        end else if (host.req) begin
            grant = gnt_host;
        end else begin
            grant = gnt_none;
        end
    end

    always_comb begin
        sel_we    = 1'b0;
        sel_addr  = host.addr;
        sel_wdata = host.wdata;
        case (grant)
            gnt_capture: begin
                sel_we    = cap.we;
                sel_addr  = cap.addr;
                sel_wdata = cap.wdata;
            end
            gnt_playback: begin
                sel_we    = play.we;
                sel_addr  = play.addr;
                sel_wdata = play.wdata;
            end
            gnt_host: sel_we = host.we;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sel_we) begin
            ram[sel_addr] <= sel_wdata;
        end
        rd_data <= ram[sel_addr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_grant <= gnt_none;
        end else begin
            rd_grant <= sel_we ? gnt_none : grant;  // Who gets rvalid next cycle
        end
    end

    assign cap.gnt  = (grant == gnt_capture);
    assign play.gnt = (grant == gnt_playback);
    assign host.gnt = (grant == gnt_host);

    assign cap.rdata  = rd_data;
    assign play.rdata = rd_data;
    assign host.rdata = rd_data;

    assign cap.rvalid  = (rd_grant == gnt_capture);
    assign play.rvalid = (rd_grant == gnt_playback);
    assign host.rvalid = (rd_grant == gnt_host);

    // A pending playback read loses at most one cycle to the writer
    a_play_served : assert property (
        @(posedge clk) disable iff (reset) play.req && !play.gnt |=> play.gnt
    );

endmodule

`default_nettype wire

// ==== echo_top.sv ====
`default_nettype none

`include "audio_defines.svh"

module echo_top import audio_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bclk,
    input  logic                       lrclk,
    input  logic                       adcda,
    output logic                       dacda,
    output logic                       bclk_s,
    output logic                       lrclk_s,
    input  logic                       host_rd,
    input  logic [`RAM_ADDR_WIDTH-1:0] host_addr,
    output frame_t                     host_rdata,
    output logic                       host_rvalid
);

    frame_t rx;
    frame_t play;
    logic   dataready;

    mem_req_if cap_mem ();
    mem_req_if play_mem ();
    mem_req_if host_mem ();

    // ########################################
    // Audio side

    i2s_port u_port (
        .clk       (clk),
        .reset     (reset),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .adcda     (adcda),
        .play      (play),
        .rx        (rx),
        .dataready (dataready),
        .bclk_s    (bclk_s),
        .lrclk_s   (lrclk_s),
        .dacda     (dacda)
    );

    capture_writer u_writer (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .dataready (dataready),
        .mem       (cap_mem.requester)
    );

    playback_reader u_reader (
        .clk       (clk),
        .reset     (reset),
        .dataready (dataready),
        .play      (play),
        .mem       (play_mem.requester)
    );

    shared_frame_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .cap   (cap_mem.arbiter),
        .play  (play_mem.arbiter),
        .host  (host_mem.arbiter)
    );

    // ########################################
    // Host read peer

    logic                       host_req;
    logic [`RAM_ADDR_WIDTH-1:0] host_addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_req <= 1'b0;
        end else if (host_rd) begin
            host_req <= 1'b1;  // Held until the arbiter serves it
        end else if (host_mem.gnt) begin
            host_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd) begin
            host_addr_q <= host_addr;
        end
    end

    assign host_mem.req   = host_req;
    assign host_mem.we    = 1'b0;
    assign host_mem.addr  = host_addr_q;
    assign host_mem.wdata = '0;

    assign host_rdata  = host_mem.rdata;
    assign host_rvalid = host_mem.rvalid;

endmodule

`default_nettype wire

// ==== echo_tb.sv ====
`default_nettype none

`include "audio_defines.svh"

module echo_tb import audio_pkg::*; ();

    typedef logic [`RAM_ADDR_WIDTH-1:0] addr_t;

    localparam int num_patterns   = 20;
    localparam int total_frames   = 25;  // Enough to hear the last pattern frame echoed
    localparam int echo_delay     = `ECHO_DELAY;
    localparam int depth          = 1 << `RAM_ADDR_WIDTH;
    localparam int sample_w       = `SAMPLE_WIDTH;
    localparam int rvalid_timeout = 20;
    localparam int frame_timeout  = 40000;

    logic   clk;
    logic   reset;
    logic   bclk;
    logic   lrclk;
    logic   adcda;
    logic   dacda;
    logic   bclk_s;
    logic   lrclk_s;
    logic   host_rd;
    addr_t  host_addr;
    frame_t host_rdata;
    logic   host_rvalid;

    logic [sample_w-1:0] pattern_words [2*num_patterns];
    int frames_started;
    int frame_errors;
    int pad_errors;
    int host_errors;
    int sync_errors;
    int timeout_errors;

    echo_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .adcda       (adcda),
        .dacda       (dacda),
        .bclk_s      (bclk_s),
        .lrclk_s     (lrclk_s),
        .host_rd     (host_rd),
        .host_addr   (host_addr),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    always #2 clk = ~clk;

    // ########################################
    // Reference model and compare tasks

    function automatic frame_t input_frame(int k);
        frame_t f;
        f = '0;  // Frames after the pattern stream are silence
        if (k < num_patterns) begin
            f.left  = pattern_words[2*k];
            f.right = pattern_words[2*k+1];
        end
        return f;
    endfunction

    function automatic frame_t expected_tx(int j);
        if (j < echo_delay + 2) begin
            return '0;
        end
        return input_frame(j - echo_delay - 2);
    endfunction

    task automatic check_frame(int idx, frame_t got, frame_t exp);
        if (got !== exp) begin
            frame_errors++;
            $display("Fail at %0t: dacda frame %0d got %h/%h expected %h/%h",
                     $time, idx, got.left, got.right, exp.left, exp.right);
        end
    endtask

    task automatic check_pad(int idx, int slot, logic [31-sample_w:0] pad);
        if (pad !== '0) begin
            pad_errors++;
            $display("Fail at %0t: frame %0d slot %0d low bits %h expected zero",
                     $time, idx, slot, pad);
        end
    endtask

    task automatic check_host(addr_t addr, frame_t got, frame_t exp);
        if (got !== exp) begin
            host_errors++;
            $display("Fail at %0t: host read address %0d got %h/%h expected %h/%h",
                     $time, addr, got.left, got.right, exp.left, exp.right);
        end
    endtask

    task automatic check_sync(string name, logic got, logic exp);
        if (got !== exp) begin
            sync_errors++;
            $display("Fail at %0t: %s is %b while the pin is %b", $time, name, got, exp);
        end
    endtask

    // ########################################
    // Codec side and dacda decoder

    task automatic run_codec();
        frame_t      in_f;
        frame_t      got_f;
        logic [31:0] slot_word;
        logic [31:0] got_word;
        for (int f = 0; f < total_frames; f++) begin
            in_f = input_frame(f);
            for (int s = 0; s < 2; s++) begin
                slot_word = 32'(s == 0 ? in_f.left : in_f.right) << (32 - sample_w);
                for (int b = 31; b >= 0; b--) begin
                    bclk  <= 1'b0;  // Left-justified, lrclk moves with the MSB
                    lrclk <= 1'(s);
                    adcda <= slot_word[b];
                    if (s == 0 && b == 31) begin
                        frames_started <= f;
                    end
                    repeat (8) @(posedge clk);
                    check_sync("bclk_s", bclk_s, 1'b0);
                    check_sync("lrclk_s", lrclk_s, 1'(s));
                    got_word[b] = dacda;  // Sampled on rising bclk like a codec would
                    bclk <= 1'b1;
                    repeat (8) @(posedge clk);
                    check_sync("bclk_s", bclk_s, 1'b1);
                end
                check_pad(f, s, got_word[31-sample_w:0]);
                if (s == 0) begin
                    got_f.left = got_word[31 -: sample_w];
                end else begin
                    got_f.right = got_word[31 -: sample_w];
                end
            end
            check_frame(f, got_f, expected_tx(f));
        end
        bclk           <= 1'b0;  // Closing lrclk edge completes the last frame
        lrclk          <= 1'b0;
        adcda          <= 1'b0;
        frames_started <= total_frames;
        repeat (64) @(posedge clk);
    endtask

    // ########################################
    // Host side

    task automatic wait_frame(int n);
        int cycles;
        cycles = 0;
        while (frames_started < n && cycles < frame_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (frames_started < n) begin
            timeout_errors++;
            $display("Timeout while waiting for frame %0d to start", n);
        end
    endtask

    task automatic host_read(addr_t addr, output frame_t data, output logic ok);
        int cycles;
        host_rd   <= 1'b1;
        host_addr <= addr;
        @(posedge clk);
        host_rd <= 1'b0;
        ok     = 1'b0;
        data   = '0;
        cycles = 0;
        while (!ok && cycles < rvalid_timeout) begin
            @(posedge clk);
            cycles++;
            if (host_rvalid) begin
                ok   = 1'b1;
                data = host_rdata;
            end
        end
        if (!ok) begin
            timeout_errors++;
            $display("Timeout: host read of address %0d never returned data", addr);
        end
    endtask

    task automatic run_host();
        frame_t data;
        logic   ok;
        int     k;
        // Back-to-back reads while frame 6 is written and frame 3 is fetched
        wait_frame(7);
        for (int i = 0; i < 12; i++) begin
            host_read(addr_t'(i % 6), data, ok);
            if (ok) begin
                check_host(addr_t'(i % 6), data, input_frame(i % 6));
            end
        end
        wait_frame(num_patterns);
        repeat (12) @(posedge clk);  // Write of the last pattern frame has retired
        for (int a = 0; a < depth; a++) begin
            k = (num_patterns - 1) - ((num_patterns - 1 - a) % depth);
            host_read(addr_t'(a), data, ok);
            if (ok) begin
                check_host(addr_t'(a), data, input_frame(k));
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        bclk           = 1'b0;
        lrclk          = 1'b0;
        adcda          = 1'b0;
        host_rd        = 1'b0;
        host_addr      = '0;
        frames_started = 0;
        frame_errors   = 0;
        pad_errors     = 0;
        host_errors    = 0;
        sync_errors    = 0;
        timeout_errors = 0;
        $readmemh("echo_patterns.txt", pattern_words);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        fork
            run_codec();
            run_host();
        join
        $display("Errors: %0d frame, %0d padding, %0d host, %0d pin sync, %0d timeout",
                 frame_errors, pad_errors, host_errors, sync_errors, timeout_errors);
        if (frame_errors + pad_errors + host_errors + sync_errors + timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== echo_patterns.txt ====
// Left and right 16-bit samples in hex
// One stereo frame per line, frame 0 first
8001 7ffe
1234 edcb
a5a5 5a5a
0f0f f0f0
c3c3 3c3c
0001 8000
fedc 0123
4567 ba98
9abc 6543
dead beef
cafe f00d
7fff 8000
1357 eca8
2468 db97
55aa aa55
ff00 00ff
3141 5926
2718 2818
6a09 e667
bb67 ae85

// ==== vlog.f ====
+incdir+.
audio_pkg.sv
mem_req_if.sv
i2s_port.sv
capture_writer.sv
playback_reader.sv
shared_frame_ram.sv
echo_top.sv
echo_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = echo_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED
SOURCES   = $(shell grep -v '^+' $(FILELIST)) audio_defines.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
